// ==== periph_soc.f ====
+incdir+include
hw/soc_pkg.sv
hw/axil_slice.sv
hw/axil_router.sv
hw/axil_sram.sv
hw/gpio_regs.sv
hw/periph_soc.sv
bench/periph_soc_tb.sv

// ==== Makefile ====
# Verilator build and run of the peripheral subsystem testbench

VERILATOR ?= verilator
TOP       ?= periph_soc_tb
FILELIST  ?= periph_soc.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# A failing check ends the run with $fatal, so the binary exits non-zero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/periph_soc_tb.sv ====
`include "soc_consts.svh"

module periph_soc_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import soc_pkg::*;

    localparam int GPIO_WIDTH = 8;
    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 10;
    localparam int SRAM_AW    = $clog2(`SOC_SRAM_BYTES);
    localparam int N_WORDS    = 32;
    localparam int N_MIX      = 120;
    localparam int N_BAD      = 8;
    localparam int N_GPIO     = 8;
    localparam int N_GIN      = 4;
    localparam int N_TXN      = 3 * N_WORDS + N_MIX + 2 * N_BAD + 1 + 3 * N_GPIO + N_GIN + 4;

    logic                  clk = 1'b0;
    logic                  arst_n;
    axil_wreq_t            wreq;
    logic                  wreq_valid;
    logic                  wreq_ready;
    axil_wrsp_t            wrsp;
    logic                  wrsp_valid;
    logic                  wrsp_ready;
    axil_rreq_t            rreq;
    logic                  rreq_valid;
    logic                  rreq_ready;
    axil_rrsp_t            rrsp;
    logic                  rrsp_valid;
    logic                  rrsp_ready;
    logic [GPIO_WIDTH-1:0] gpio_in;
    logic [GPIO_WIDTH-1:0] gpio_out;

    // Reference model and expected responses
    logic [7:0]            sram_model [`SOC_SRAM_BYTES];
    logic [SRAM_AW-1:0]    word_ofs [N_WORDS];
    logic [GPIO_WIDTH-1:0] out_model = '0;
    axil_wrsp_t            exp_wq [$];
    axil_rrsp_t            exp_rq [$];
    axil_wrsp_t            exp_w_head = '0;
    axil_rrsp_t            exp_r_head = '0;
    int                    w_cnt = 0;
    int                    r_cnt = 0;
    logic                  w_pop = 1'b0;
    logic                  r_pop = 1'b0;

    // Responses transferred at the DUT port
    int                    n_rsp = 0;

    // Previous-cycle copies for the back-pressure checks
    axil_wrsp_t            prev_wrsp;
    axil_rrsp_t            prev_rrsp;
    logic                  w_held = 1'b0;
    logic                  r_held = 1'b0;
    logic                  in_reset_q = 1'b0;

    periph_soc #(.GPIO_WIDTH(GPIO_WIDTH)) DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .wreq       (wreq),
        .wreq_valid (wreq_valid),
        .wreq_ready (wreq_ready),
        .wrsp       (wrsp),
        .wrsp_valid (wrsp_valid),
        .wrsp_ready (wrsp_ready),
        .rreq       (rreq),
        .rreq_valid (rreq_valid),
        .rreq_ready (rreq_ready),
        .rrsp       (rrsp),
        .rrsp_valid (rrsp_valid),
        .rrsp_ready (rrsp_ready),
        .gpio_in    (gpio_in),
        .gpio_out   (gpio_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    // Queue heads advance one negedge after the handshake was seen
    always @(negedge clk) begin
        if (w_pop) begin
            void'(exp_wq.pop_front());
        end
        if (r_pop) begin
            void'(exp_rq.pop_front());
        end
        w_pop      = wrsp_valid && wrsp_ready;
        r_pop      = rrsp_valid && rrsp_ready;
        w_cnt      = exp_wq.size();
        r_cnt      = exp_rq.size();
        exp_w_head = (w_cnt != 0) ? exp_wq[0] : '0;
        exp_r_head = (r_cnt != 0) ? exp_rq[0] : '0;
    end

    always @(posedge clk) begin
        in_reset_q <= !arst_n;
        prev_wrsp  <= wrsp;
        prev_rrsp  <= rrsp;
        w_held     <= wrsp_valid && !wrsp_ready;
        r_held     <= rrsp_valid && !rrsp_ready;
        n_rsp      <= n_rsp + int'(wrsp_valid && wrsp_ready) + int'(rrsp_valid && rrsp_ready);
    end

    a_reset_state: assert property (@(posedge clk)
        in_reset_q |-> !wrsp_valid && !rrsp_valid && !wreq_ready && !rreq_ready
                       && gpio_out == '0)
        else report_fail("Outputs are not in their reset state during or right after reset");

    a_wrsp_value: assert property (@(posedge clk) disable iff (!arst_n)
        wrsp_valid && wrsp_ready |-> wrsp == exp_w_head)
        else report_fail($sformatf("ERR wrsp exp %h got %h",
                                   $sampled(exp_w_head), $sampled(wrsp)));

    a_rrsp_value: assert property (@(posedge clk) disable iff (!arst_n)
        rrsp_valid && rrsp_ready |-> rrsp == exp_r_head)
        else report_fail($sformatf("ERR rrsp exp %h got %h",
                                   $sampled(exp_r_head), $sampled(rrsp)));

    a_wrsp_expected: assert property (@(posedge clk) disable iff (!arst_n)
        wrsp_valid |-> w_cnt != 0)
        else report_fail("Write response valid with no write request outstanding");

    a_rrsp_expected: assert property (@(posedge clk) disable iff (!arst_n)
        rrsp_valid |-> r_cnt != 0)
        else report_fail("Read response valid with no read request outstanding");

    a_wrsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        w_held |-> wrsp_valid && wrsp == prev_wrsp)
        else report_fail($sformatf("ERR wrsp under back-pressure exp %h got %h valid %h",
                                   $sampled(prev_wrsp), $sampled(wrsp),
                                   $sampled(wrsp_valid)));

    a_rrsp_hold: assert property (@(posedge clk) disable iff (!arst_n)
        r_held |-> rrsp_valid && rrsp == prev_rrsp)
        else report_fail($sformatf("ERR rrsp under back-pressure exp %h got %h valid %h",
                                   $sampled(prev_rrsp), $sampled(rrsp),
                                   $sampled(rrsp_valid)));

    // Output register is only compared once every write has been answered
    a_gpio_out: assert property (@(posedge clk) disable iff (!arst_n)
        w_cnt == 0 |-> gpio_out == out_model)
        else report_fail($sformatf("ERR gpio_out exp %h got %h",
                                   $sampled(out_model), $sampled(gpio_out)));

    task automatic wait_idle();
        do begin
            @(posedge clk);
            #1;
        end while (exp_wq.size() != 0 || exp_rq.size() != 0);
    endtask

    task automatic bus_write(input logic [`SOC_ADDR_W-1:0] addr,
                             input logic [`SOC_DATA_W-1:0] data,
                             input logic [`SOC_STRB_W-1:0] strb, input axil_resp_e resp);
        axil_wrsp_t want;
        logic       taken;
        want.resp = resp;
        exp_wq.push_back(want);
        wreq       = '{addr: addr, data: data, strb: strb};
        wreq_valid = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = wreq_ready;
            @(posedge clk);
            #1;
        end
        wreq_valid = 1'b0;
        wait_idle();
    endtask

    task automatic bus_read(input logic [`SOC_ADDR_W-1:0] addr, input axil_rrsp_t want);
        logic taken;
        exp_rq.push_back(want);
        rreq.addr  = addr;
        rreq_valid = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = rreq_ready;
            @(posedge clk);
            #1;
        end
        rreq_valid = 1'b0;
        wait_idle();
    endtask

    task automatic sram_write(input logic [SRAM_AW-1:0] ofs, input logic [`SOC_DATA_W-1:0] data,
                              input logic [`SOC_STRB_W-1:0] strb);
        for (int b = 0; b < `SOC_STRB_W; b++) begin
            if (strb[b]) begin
                sram_model[ofs + SRAM_AW'(b)] = data[8*b +: 8];
            end
        end
        bus_write(`SOC_SRAM_BASE + 32'(ofs), data, strb, OKAY);
    endtask

    task automatic sram_read(input logic [SRAM_AW-1:0] ofs);
        axil_rrsp_t want;
        want.resp = OKAY;
        for (int b = 0; b < `SOC_STRB_W; b++) begin
            want.data[8*b +: 8] = sram_model[ofs + SRAM_AW'(b)];
        end
        bus_read(`SOC_SRAM_BASE + 32'(ofs), want);
    endtask

    task automatic gpio_write(input int ofs, input logic [`SOC_DATA_W-1:0] data,
                              input logic [`SOC_STRB_W-1:0] strb);
        axil_resp_e resp;
        resp = SLVERR;
        if (ofs == `GPIO_OUT_OFS || ofs == `GPIO_TGL_OFS) begin
            resp = OKAY;
            for (int i = 0; i < GPIO_WIDTH; i++) begin
                if (strb[i / 8]) begin
                    out_model[i] = (ofs == `GPIO_OUT_OFS) ? data[i] : out_model[i] ^ data[i];
                end
            end
        end
        bus_write(`SOC_GPIO_BASE + ofs, data, strb, resp);
    endtask

    task automatic gpio_read(input int ofs);
        axil_rrsp_t want;
        want = '{data: '0, resp: SLVERR};
        if (ofs == `GPIO_OUT_OFS) begin
            want.data[GPIO_WIDTH-1:0] = out_model;
            want.resp                 = OKAY;
        end else if (ofs == `GPIO_IN_OFS) begin
            want.data[GPIO_WIDTH-1:0] = gpio_in;
            want.resp                 = OKAY;
        end
        bus_read(`SOC_GPIO_BASE + ofs, want);
    endtask

    // Addresses just outside both windows, plus low addresses that alias into SRAM offsets
    function automatic logic [`SOC_ADDR_W-1:0] unmapped_addr(input int i);
        case (i)
            0:       return 32'h0000_0000;
            1:       return `SOC_SRAM_BASE - 4;
            2:       return `SOC_SRAM_BASE + `SOC_SRAM_BYTES;
            3:       return `SOC_GPIO_BASE - 4;
            4:       return `SOC_GPIO_BASE + `SOC_GPIO_SPAN;
            5:       return 32'h3000_0000;
            6:       return 32'hFFFF_FFFC;
            default: return $urandom & 32'h0FFF_FFFC;
        endcase
    endfunction

    // Random back-pressure on both response channels
    initial begin
        @(posedge arst_n);
        forever begin
            @(posedge clk);
            #1;
            wrsp_ready = ($urandom_range(3) != 0);
            rrsp_ready = ($urandom_range(3) != 0);
        end
    end

    initial begin
        #((N_TXN * 50 + RST_CYCLES) * CLK_PERIOD);
        report_fail("Run timed out before all transactions completed");
    end

    initial begin
        int                     idx;
        logic [`SOC_ADDR_W-1:0] bad;
        axil_rrsp_t             dec_rsp;
        void'($urandom(82875));
        arst_n     = 1'b0;
        wreq       = '0;
        wreq_valid = 1'b0;
        wrsp_ready = 1'b0;
        rreq       = '0;
        rreq_valid = 1'b0;
        rrsp_ready = 1'b0;
        gpio_in    = '0;
        dec_rsp    = '{data: '0, resp: DECERR};
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // SRAM words spread over the whole array, fully written first
        for (int i = 0; i < N_WORDS; i++) begin
            word_ofs[i] = SRAM_AW'($urandom_range(`SOC_SRAM_BYTES / 4 - 1) * 4);
            sram_write(word_ofs[i], $urandom, '1);
        end
        for (int i = 0; i < N_MIX; i++) begin
            idx = $urandom_range(N_WORDS - 1);
            if ($urandom_range(1) == 1) begin
                sram_write(word_ofs[idx], $urandom, 4'($urandom));
            end else begin
                sram_read(word_ofs[idx]);
            end
        end
        for (int i = 0; i < N_WORDS; i++) begin
            sram_read(word_ofs[i]);
        end

        for (int i = 0; i < N_BAD; i++) begin
            bad = unmapped_addr(i);
            bus_write(bad, $urandom, '1, DECERR);
            bus_read(bad, dec_rsp);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            sram_read(word_ofs[i]);
        end
        gpio_read(`GPIO_OUT_OFS);

        for (int i = 0; i < N_GPIO; i++) begin
            gpio_write(`GPIO_OUT_OFS, $urandom, 4'($urandom));
            gpio_write(`GPIO_TGL_OFS, $urandom, '1);
            gpio_read(`GPIO_OUT_OFS);
        end

        // Input value settles through the synchronizer before the read
        for (int i = 0; i < N_GIN; i++) begin
            gpio_in = GPIO_WIDTH'($urandom);
            repeat (4) @(posedge clk);
            #1;
            gpio_read(`GPIO_IN_OFS);
        end
        gpio_write(`GPIO_IN_OFS, $urandom, '1);
        gpio_read(`GPIO_TGL_OFS);
        gpio_read('hC);
        gpio_write('hC, $urandom, '1);

        if (n_rsp == N_TXN) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_fail($sformatf("ERR n_rsp exp %h got %h", N_TXN, n_rsp));
        end
    end

endmodule

// ==== hw/periph_soc.sv ====
module periph_soc #(
    parameter int GPIO_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,

    input  soc_pkg::axil_wreq_t   wreq,
    input  logic                  wreq_valid,
    output logic                  wreq_ready,
    output soc_pkg::axil_wrsp_t   wrsp,
    output logic                  wrsp_valid,
    input  logic                  wrsp_ready,
    input  soc_pkg::axil_rreq_t   rreq,
    input  logic                  rreq_valid,
    output logic                  rreq_ready,
    output soc_pkg::axil_rrsp_t   rrsp,
    output logic                  rrsp_valid,
    input  logic                  rrsp_ready,

    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out
);

    import soc_pkg::*;

    // Sliced master requests
    axil_wreq_t s_wreq;
    logic       s_wreq_valid;
    logic       s_wreq_ready;
    axil_rreq_t s_rreq;
    logic       s_rreq_valid;
    logic       s_rreq_ready;

    // Device channels
    axil_wreq_t sram_wreq;
    axil_wrsp_t sram_wrsp;
    axil_rreq_t sram_rreq;
    axil_rrsp_t sram_rrsp;
    logic       sram_wreq_valid;
    logic       sram_wreq_ready;
    logic       sram_wrsp_valid;
    logic       sram_wrsp_ready;
    logic       sram_rreq_valid;
    logic       sram_rreq_ready;
    logic       sram_rrsp_valid;
    logic       sram_rrsp_ready;
    axil_wreq_t gpio_wreq;
    axil_wrsp_t gpio_wrsp;
    axil_rreq_t gpio_rreq;
    axil_rrsp_t gpio_rrsp;
    logic       gpio_wreq_valid;
    logic       gpio_wreq_ready;
    logic       gpio_wrsp_valid;
    logic       gpio_wrsp_ready;
    logic       gpio_rreq_valid;
    logic       gpio_rreq_ready;
    logic       gpio_rrsp_valid;
    logic       gpio_rrsp_ready;

    axil_slice #(.T(axil_wreq_t)) wreq_slice (
        .clk,
        .arst_n,
        .in_data   (wreq),
        .in_valid  (wreq_valid),
        .in_ready  (wreq_ready),
        .out_data  (s_wreq),
        .out_valid (s_wreq_valid),
        .out_ready (s_wreq_ready)
    );

    axil_slice #(.T(axil_rreq_t)) rreq_slice (
        .clk,
        .arst_n,
        .in_data   (rreq),
        .in_valid  (rreq_valid),
        .in_ready  (rreq_ready),
        .out_data  (s_rreq),
        .out_valid (s_rreq_valid),
        .out_ready (s_rreq_ready)
    );

    axil_router router (
        .clk,
        .arst_n,
        .m_wreq       (s_wreq),
        .m_wreq_valid (s_wreq_valid),
        .m_wreq_ready (s_wreq_ready),
        .m_wrsp       (wrsp),
        .m_wrsp_valid (wrsp_valid),
        .m_wrsp_ready (wrsp_ready),
        .m_rreq       (s_rreq),
        .m_rreq_valid (s_rreq_valid),
        .m_rreq_ready (s_rreq_ready),
        .m_rrsp       (rrsp),
        .m_rrsp_valid (rrsp_valid),
        .m_rrsp_ready (rrsp_ready),
        .sram_wreq,
        .sram_wreq_valid,
        .sram_wreq_ready,
        .sram_wrsp,
        .sram_wrsp_valid,
        .sram_wrsp_ready,
        .sram_rreq,
        .sram_rreq_valid,
        .sram_rreq_ready,
        .sram_rrsp,
        .sram_rrsp_valid,
        .sram_rrsp_ready,
        .gpio_wreq,
        .gpio_wreq_valid,
        .gpio_wreq_ready,
        .gpio_wrsp,
        .gpio_wrsp_valid,
        .gpio_wrsp_ready,
        .gpio_rreq,
        .gpio_rreq_valid,
        .gpio_rreq_ready,
        .gpio_rrsp,
        .gpio_rrsp_valid,
        .gpio_rrsp_ready
    );

    axil_sram sram (
        .clk,
        .arst_n,
        .wreq       (sram_wreq),
        .wreq_valid (sram_wreq_valid),
        .wreq_ready (sram_wreq_ready),
        .wrsp       (sram_wrsp),
        .wrsp_valid (sram_wrsp_valid),
        .wrsp_ready (sram_wrsp_ready),
        .rreq       (sram_rreq),
        .rreq_valid (sram_rreq_valid),
        .rreq_ready (sram_rreq_ready),
        .rrsp       (sram_rrsp),
        .rrsp_valid (sram_rrsp_valid),
        .rrsp_ready (sram_rrsp_ready)
    );

    gpio_regs #(.GPIO_WIDTH(GPIO_WIDTH)) gpio (
        .clk,
        .arst_n,
        .wreq       (gpio_wreq),
        .wreq_valid (gpio_wreq_valid),
        .wreq_ready (gpio_wreq_ready),
        .wrsp       (gpio_wrsp),
        .wrsp_valid (gpio_wrsp_valid),
        .wrsp_ready (gpio_wrsp_ready),
        .rreq       (gpio_rreq),
        .rreq_valid (gpio_rreq_valid),
        .rreq_ready (gpio_rreq_ready),
        .rrsp       (gpio_rrsp),
        .rrsp_valid (gpio_rrsp_valid),
        .rrsp_ready (gpio_rrsp_ready),
        .gpio_in,
        .gpio_out
    );

endmodule

// ==== hw/gpio_regs.sv ====
`include "soc_consts.svh"

module gpio_regs #(
    parameter int GPIO_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,

    input  soc_pkg::axil_wreq_t   wreq,
    input  logic                  wreq_valid,
    output logic                  wreq_ready,
    output soc_pkg::axil_wrsp_t   wrsp,
    output logic                  wrsp_valid,
    input  logic                  wrsp_ready,

    input  soc_pkg::axil_rreq_t   rreq,
    input  logic                  rreq_valid,
    output logic                  rreq_ready,
    output soc_pkg::axil_rrsp_t   rrsp,
    output logic                  rrsp_valid,
    input  logic                  rrsp_ready,

    input  logic [GPIO_WIDTH-1:0] gpio_in,
    output logic [GPIO_WIDTH-1:0] gpio_out
);

    import soc_pkg::*;

    localparam int OFS_W = $clog2(`SOC_GPIO_SPAN);

    logic [GPIO_WIDTH-1:0]  out_q;
    logic [GPIO_WIDTH-1:0]  sync_q1;
    logic [GPIO_WIDTH-1:0]  sync_q2;
    logic [`SOC_DATA_W-1:0] wmask;
    logic [GPIO_WIDTH-1:0]  wbits;
    logic [OFS_W-1:0]       wofs;
    logic [OFS_W-1:0]       rofs;
    logic                   wr_acc;

    assign wofs       = wreq.addr[OFS_W-1:0];
    assign rofs       = rreq.addr[OFS_W-1:0];
    assign wr_acc     = wreq_valid && wreq_ready;
    assign wreq_ready = !wrsp_valid;
    assign rreq_ready = !rrsp_valid;
    assign gpio_out   = out_q;

    // Byte strobes limit which output bits a write touches
    always_comb begin
        for (int b = 0; b < `SOC_STRB_W; b++) begin
            wmask[8*b +: 8] = {8{wreq.strb[b]}};
        end
    end
    assign wbits = wreq.data[GPIO_WIDTH-1:0] & wmask[GPIO_WIDTH-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_q   <= '0;
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= gpio_in;
            sync_q2 <= sync_q1;
            if (wr_acc && wofs == OFS_W'(`GPIO_OUT_OFS)) begin
                out_q <= (out_q & ~wmask[GPIO_WIDTH-1:0]) | wbits;
            end else if (wr_acc && wofs == OFS_W'(`GPIO_TGL_OFS)) begin
                out_q <= out_q ^ wbits;
            end
        end
    end

    // Response payloads are captured on accept and held
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            if (wofs == OFS_W'(`GPIO_OUT_OFS) || wofs == OFS_W'(`GPIO_TGL_OFS)) begin
                wrsp.resp <= OKAY;
            end else begin
                wrsp.resp <= SLVERR;
            end
        end
        if (rreq_valid && rreq_ready) begin
            if (rofs == OFS_W'(`GPIO_OUT_OFS)) begin
                rrsp <= '{data: `SOC_DATA_W'(out_q), resp: OKAY};
            end else if (rofs == OFS_W'(`GPIO_IN_OFS)) begin
                rrsp <= '{data: `SOC_DATA_W'(sync_q2), resp: OKAY};
            end else begin
                rrsp <= '{data: '0, resp: SLVERR};
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wrsp_valid <= 1'b0;
            rrsp_valid <= 1'b0;
        end else begin
            if (wr_acc) begin
                wrsp_valid <= 1'b1;
            end else if (wrsp_ready) begin
                wrsp_valid <= 1'b0;
            end
            if (rreq_valid && rreq_ready) begin
                rrsp_valid <= 1'b1;
            end else if (rrsp_ready) begin
                rrsp_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/axil_sram.sv ====
`include "soc_consts.svh"

module axil_sram (
    input  logic                clk,
    input  logic                arst_n,

    input  soc_pkg::axil_wreq_t wreq,
    input  logic                wreq_valid,
    output logic                wreq_ready,
    output soc_pkg::axil_wrsp_t wrsp,
    output logic                wrsp_valid,
    input  logic                wrsp_ready,

    input  soc_pkg::axil_rreq_t rreq,
    input  logic                rreq_valid,
    output logic                rreq_ready,
    output soc_pkg::axil_rrsp_t rrsp,
    output logic                rrsp_valid,
    input  logic                rrsp_ready
);

    import soc_pkg::*;

    localparam int WORDS = `SOC_SRAM_BYTES / 4;
    localparam int IDX_W = $clog2(WORDS);

    logic [`SOC_DATA_W-1:0] mem [WORDS];
    logic [`SOC_DATA_W-1:0] rd_data;
    logic [IDX_W-1:0]       widx;
    logic [IDX_W-1:0]       ridx;

    // Word index wraps within the array
    assign widx = wreq.addr[IDX_W+1:2];
    assign ridx = rreq.addr[IDX_W+1:2];

    assign wreq_ready = !wrsp_valid;
    assign rreq_ready = !rrsp_valid;
    assign wrsp       = '{resp: OKAY};
    assign rrsp       = '{data: rd_data, resp: OKAY};

    always_ff @(posedge clk) begin
        if (wreq_valid && wreq_ready) begin
            for (int b = 0; b < `SOC_STRB_W; b++) begin
                if (wreq.strb[b]) begin
                    mem[widx][8*b +: 8] <= wreq.data[8*b +: 8];
                end
            end
        end
        if (rreq_valid && rreq_ready) begin
            rd_data <= mem[ridx];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wrsp_valid <= 1'b0;
            rrsp_valid <= 1'b0;
        end else begin
            if (wreq_valid && wreq_ready) begin
                wrsp_valid <= 1'b1;
            end else if (wrsp_ready) begin
                wrsp_valid <= 1'b0;
            end
            if (rreq_valid && rreq_ready) begin
                rrsp_valid <= 1'b1;
            end else if (rrsp_ready) begin
                rrsp_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/axil_router.sv ====
`include "soc_consts.svh"

module axil_router (
    input  logic                clk,
    input  logic                arst_n,

    // Master side
    input  soc_pkg::axil_wreq_t m_wreq,
    input  logic                m_wreq_valid,
    output logic                m_wreq_ready,
    output soc_pkg::axil_wrsp_t m_wrsp,
    output logic                m_wrsp_valid,
    input  logic                m_wrsp_ready,
    input  soc_pkg::axil_rreq_t m_rreq,
    input  logic                m_rreq_valid,
    output logic                m_rreq_ready,
    output soc_pkg::axil_rrsp_t m_rrsp,
    output logic                m_rrsp_valid,
    input  logic                m_rrsp_ready,

    // SRAM
    output soc_pkg::axil_wreq_t sram_wreq,
    output logic                sram_wreq_valid,
    input  logic                sram_wreq_ready,
    input  soc_pkg::axil_wrsp_t sram_wrsp,
    input  logic                sram_wrsp_valid,
    output logic                sram_wrsp_ready,
    output soc_pkg::axil_rreq_t sram_rreq,
    output logic                sram_rreq_valid,
    input  logic                sram_rreq_ready,
    input  soc_pkg::axil_rrsp_t sram_rrsp,
    input  logic                sram_rrsp_valid,
    output logic                sram_rrsp_ready,

    // GPIO
    output soc_pkg::axil_wreq_t gpio_wreq,
    output logic                gpio_wreq_valid,
    input  logic                gpio_wreq_ready,
    input  soc_pkg::axil_wrsp_t gpio_wrsp,
    input  logic                gpio_wrsp_valid,
    output logic                gpio_wrsp_ready,
    output soc_pkg::axil_rreq_t gpio_rreq,
    output logic                gpio_rreq_valid,
    input  logic                gpio_rreq_ready,
    input  soc_pkg::axil_rrsp_t gpio_rrsp,
    input  logic                gpio_rrsp_valid,
    output logic                gpio_rrsp_ready
);

    import soc_pkg::*;

    typedef enum logic [1:0] {
        TGT_SRAM,
        TGT_GPIO,
        TGT_ERR
    } tgt_e;

    function automatic tgt_e decode(input logic [`SOC_ADDR_W-1:0] addr);
        if (addr - `SOC_SRAM_BASE < `SOC_SRAM_BYTES) begin
            return TGT_SRAM;
        end
        if (addr - `SOC_GPIO_BASE < `SOC_GPIO_SPAN) begin
            return TGT_GPIO;
        end
        return TGT_ERR;
    endfunction

    tgt_e w_dec;
    tgt_e w_tgt;
    tgt_e r_dec;
    tgt_e r_tgt;
    logic w_pend;
    logic r_pend;

    assign w_dec = decode(m_wreq.addr);
    assign r_dec = decode(m_rreq.addr);

    // Requests fan out to both devices; only valid is steered
    assign sram_wreq       = m_wreq;
    assign gpio_wreq       = m_wreq;
    assign sram_wreq_valid = m_wreq_valid && !w_pend && (w_dec == TGT_SRAM);
    assign gpio_wreq_valid = m_wreq_valid && !w_pend && (w_dec == TGT_GPIO);
    assign sram_rreq       = m_rreq;
    assign gpio_rreq       = m_rreq;
    assign sram_rreq_valid = m_rreq_valid && !r_pend && (r_dec == TGT_SRAM);
    assign gpio_rreq_valid = m_rreq_valid && !r_pend && (r_dec == TGT_GPIO);

    always_comb begin
        case (w_dec)
            TGT_SRAM: m_wreq_ready = !w_pend && sram_wreq_ready;
            TGT_GPIO: m_wreq_ready = !w_pend && gpio_wreq_ready;
            default:  m_wreq_ready = !w_pend;
        endcase
        case (r_dec)
            TGT_SRAM: m_rreq_ready = !r_pend && sram_rreq_ready;
            TGT_GPIO: m_rreq_ready = !r_pend && gpio_rreq_ready;
            default:  m_rreq_ready = !r_pend;
        endcase
    end

    // Responses come from the owner of the pending transfer
    always_comb begin
        m_wrsp       = '{resp: DECERR};
        m_wrsp_valid = w_pend;
        case (w_tgt)
            TGT_SRAM: begin
                m_wrsp       = sram_wrsp;
                m_wrsp_valid = w_pend && sram_wrsp_valid;
            end
            TGT_GPIO: begin
                m_wrsp       = gpio_wrsp;
                m_wrsp_valid = w_pend && gpio_wrsp_valid;
            end
            default: ;
        endcase
    end

    always_comb begin
        m_rrsp       = '{data: '0, resp: DECERR};
        m_rrsp_valid = r_pend;
        case (r_tgt)
            TGT_SRAM: begin
                m_rrsp       = sram_rrsp;
                m_rrsp_valid = r_pend && sram_rrsp_valid;
            end
            TGT_GPIO: begin
                m_rrsp       = gpio_rrsp;
                m_rrsp_valid = r_pend && gpio_rrsp_valid;
            end
            default: ;
        endcase
    end

    assign sram_wrsp_ready = m_wrsp_ready && w_pend && (w_tgt == TGT_SRAM);
    assign gpio_wrsp_ready = m_wrsp_ready && w_pend && (w_tgt == TGT_GPIO);
    assign sram_rrsp_ready = m_rrsp_ready && r_pend && (r_tgt == TGT_SRAM);
    assign gpio_rrsp_ready = m_rrsp_ready && r_pend && (r_tgt == TGT_GPIO);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_pend <= 1'b0;
            w_tgt  <= TGT_ERR;
        end else if (m_wreq_valid && m_wreq_ready) begin
            w_pend <= 1'b1;
            w_tgt  <= w_dec;
        end else if (m_wrsp_valid && m_wrsp_ready) begin
            w_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_pend <= 1'b0;
            r_tgt  <= TGT_ERR;
        end else if (m_rreq_valid && m_rreq_ready) begin
            r_pend <= 1'b1;
            r_tgt  <= r_dec;
        end else if (m_rrsp_valid && m_rrsp_ready) begin
            r_pend <= 1'b0;
        end
    end

endmodule

// ==== hw/axil_slice.sv ====
module axil_slice #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arst_n,

    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,

    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    T     main_data;
    T     spill_data;
    logic main_valid;
    logic spill_valid;
    logic main_valid_d;
    logic spill_valid_d;
    logic take_in;
    logic load_main;
    logic load_spill;
    logic main_from_spill;

    assign take_in   = in_valid && in_ready;
    assign out_data  = main_data;
    assign out_valid = main_valid;

    always_comb begin
        main_valid_d    = main_valid;
        spill_valid_d   = spill_valid;
        load_main       = 1'b0;
        load_spill      = 1'b0;
        main_from_spill = 1'b0;
        if (out_ready || !main_valid) begin
            // Main register drains; refill from spill first to keep order
            if (spill_valid) begin
                main_valid_d    = 1'b1;
                spill_valid_d   = 1'b0;
                main_from_spill = 1'b1;
            end else begin
                main_valid_d = take_in;
                load_main    = take_in;
            end
        end else if (take_in) begin
            spill_valid_d = 1'b1;
            load_spill    = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            main_valid  <= 1'b0;
            spill_valid <= 1'b0;
            in_ready    <= 1'b0;
        end else begin
            main_valid  <= main_valid_d;
            spill_valid <= spill_valid_d;
            in_ready    <= !spill_valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (load_spill) begin
            spill_data <= in_data;
        end
        if (main_from_spill) begin
            main_data <= spill_data;
        end else if (load_main) begin
            main_data <= in_data;
        end
    end

endmodule

// ==== hw/soc_pkg.sv ====
`include "soc_consts.svh"

package soc_pkg;

    typedef enum logic [1:0] {
        OKAY   = `SOC_RESP_OKAY,
        SLVERR = `SOC_RESP_SLVERR,
        DECERR = `SOC_RESP_DECERR
    } axil_resp_e;

    // Write address and data share one request channel
    typedef struct packed {
        logic [`SOC_ADDR_W-1:0] addr;
        logic [`SOC_DATA_W-1:0] data;
        logic [`SOC_STRB_W-1:0] strb;
    } axil_wreq_t;

    typedef struct packed {
        axil_resp_e resp;
    } axil_wrsp_t;

    typedef struct packed {
        logic [`SOC_ADDR_W-1:0] addr;
    } axil_rreq_t;

    typedef struct packed {
        logic [`SOC_DATA_W-1:0] data;
        axil_resp_e             resp;
    } axil_rrsp_t;

endpackage

// ==== include/soc_consts.svh ====
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// Bus widths
`define SOC_ADDR_W      32
`define SOC_DATA_W      32
`define SOC_STRB_W      (`SOC_DATA_W / 8)

// Address map
`define SOC_SRAM_BASE   32'h1000_0000
`define SOC_GPIO_BASE   32'h2000_0000
`define SOC_SRAM_BYTES  4096
`define SOC_GPIO_SPAN   16

// GPIO register offsets within the window
`define GPIO_OUT_OFS    'h0
`define GPIO_IN_OFS     'h4
`define GPIO_TGL_OFS    'h8

// Response codes
`define SOC_RESP_OKAY   2'b00
`define SOC_RESP_SLVERR 2'b10
`define SOC_RESP_DECERR 2'b11

`endif
